// File: Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb -f flist.f -o sim_bin
	./obj_dir/sim_bin > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: bench/ooo_core_sva.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_core_sva (
    input wire                         clk,
    input wire                         rst,
    input wire                         issue_valid,
    input wire                         issue_ready,
    input wire [ooo_pkg::ALU_CNT-1:0]  slot_load,
    input wire ooo_pkg::result_bus_t   result0,
    input wire ooo_pkg::result_bus_t   result1
);

    a_issue_ready: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> issue_ready)
        else $error("Issue strobe while the station was full.");

    a_bus_tags: assert property (@(posedge clk) disable iff (rst)
        (result0.valid && result1.valid) |-> (result0.tag != result1.tag))
        else $error("Both result buses carried the same tag.");

    a_slot_load: assert property (@(posedge clk) disable iff (rst)
        $onehot0(slot_load))
        else $error("More than one slot loaded at once.");

    // First cycle out of reset.
    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> (!result0.valid && !result1.valid && issue_ready))
        else $error("Core not idle in the cycle after reset.");

endmodule

bind ooo_core ooo_core_sva ooo_core_sva_inst (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .slot_load   (slot_load),
    .result0     (result0),
    .result1     (result1)
);

`default_nettype wire

// File: bench/ooo_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_core_tb;

    import ooo_pkg::*;

    localparam int INSTR_BUDGET   = 500;
    localparam int CYCLES_PER_INS = 8;
    localparam int TIMEOUT_CYCLES = INSTR_BUDGET * CYCLES_PER_INS;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic                  issue_valid = 1'b0;
    instr_u                issue_instr = '0;
    logic                  issue_ready;
    result_bus_t           result0;
    result_bus_t           result1;
    logic [REG_ADDR_W-1:0] result_rd0;
    logic [REG_ADDR_W-1:0] result_rd1;

    logic [WORD_W-1:0]     model_regs [REG_CNT];
    logic [WORD_W-1:0]     exp_data [1 << TAG_W];  // Indexed by rename tag.
    logic [REG_ADDR_W-1:0] exp_rd [1 << TAG_W];
    logic [TAG_W-1:0]      next_tag = '0;
    int                    seed = 32'h4e6d0d3e;
    int                    issued = 0;
    int                    retired = 0;
    int                    errors = 0;
    int                    tests = 0;
    int                    cycles = 0;
    int                    test_err0 = 0;
    int                    test_iss0 = 0;
    string                 test_name = "reset";

    ooo_core #(.MUL_LAT(3)) ooo_core_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_ready (issue_ready),
        .result0     (result0),
        .result1     (result1),
        .result_rd0  (result_rd0),
        .result_rd1  (result_rd1)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!rst) begin
            retired <= retired + int'(result0.valid) + int'(result1.valid);
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run hung in test %s after %0d cycles.", test_name, cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic void report_mismatch(string what, logic [WORD_W-1:0] expv,
                                            logic [WORD_W-1:0] actv);
        $display("Fail %s %s expected %h actual %h", test_name, what, expv, actv);
        errors++;
    endfunction

    a_data0: assert property (@(posedge clk) disable iff (rst)
        result0.valid |-> result0.data == exp_data[result0.tag])
        else report_mismatch("bus 0 data", exp_data[$sampled(result0.tag)],
                             $sampled(result0.data));
    a_rd0: assert property (@(posedge clk) disable iff (rst)
        result0.valid |-> result_rd0 == exp_rd[result0.tag])
        else report_mismatch("bus 0 rd", WORD_W'(exp_rd[$sampled(result0.tag)]),
                             WORD_W'($sampled(result_rd0)));
    a_data1: assert property (@(posedge clk) disable iff (rst)
        result1.valid |-> result1.data == exp_data[result1.tag])
        else report_mismatch("bus 1 data", exp_data[$sampled(result1.tag)],
                             $sampled(result1.data));
    a_rd1: assert property (@(posedge clk) disable iff (rst)
        result1.valid |-> result_rd1 == exp_rd[result1.tag])
        else report_mismatch("bus 1 rd", WORD_W'(exp_rd[$sampled(result1.tag)]),
                             WORD_W'($sampled(result_rd1)));

    // In-order architectural result of one instruction.
    function automatic logic [WORD_W-1:0] expected_value(op_e op, logic [WORD_W-1:0] x,
                                                         logic [WORD_W-1:0] y);
        case (op)
            OP_ADD, OP_ADDI: return x + y;
            OP_SUB:          return x - y;
            OP_AND:          return x & y;
            OP_OR:           return x | y;
            OP_XOR:          return x ^ y;
            OP_SLL:          return x << y[4:0];
            default:         return x * y;  // Low word of the product.
        endcase
    endfunction

    task automatic issue(input op_e op, input int rd, input int rs, input int rt,
                         input int imm);
        instr_u            w;
        logic [IMM_W-1:0]  imm_w;
        logic [WORD_W-1:0] y;
        w = '0;
        imm_w = IMM_W'(imm);
        w.r_fmt.opcode = OPC_W'(op);
        w.r_fmt.rd = REG_ADDR_W'(rd);
        w.r_fmt.rs = REG_ADDR_W'(rs);
        if (op == OP_ADDI) begin
            w.i_fmt.imm = imm_w;
            y = {{(WORD_W-IMM_W){imm_w[IMM_W-1]}}, imm_w};
        end else begin
            w.r_fmt.rt = REG_ADDR_W'(rt);
            y = model_regs[rt];
        end
        issue_valid = 1'b0;
        while (!issue_ready) @(negedge clk);
        next_tag = (next_tag == '1) ? TAG_W'(1) : next_tag + TAG_W'(1);  // Skips zero.
        exp_data[next_tag] = expected_value(op, model_regs[rs], y);
        exp_rd[next_tag] = REG_ADDR_W'(rd);
        model_regs[rd] = exp_data[next_tag];
        issue_instr = w;
        issue_valid = 1'b1;
        issued++;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic drain();
        while (retired != issued) @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
        test_iss0 = issued;
    endtask

    task automatic end_test();
        drain();
        tests++;
        $display("Test %s done: %0d instructions, %0d errors", test_name,
                 issued - test_iss0, errors - test_err0);
    endtask

    initial begin
        logic [31:0] rnd;
        for (int r = 0; r < REG_CNT; r++) begin
            model_regs[r] = '0;
        end
        begin_test("reset");
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        a_idle: assert (issue_ready === 1'b1 && !result0.valid && !result1.valid)
            else report_mismatch("idle outputs", 32'b100,
                                 {29'b0, issue_ready, result0.valid, result1.valid});
        end_test();

        begin_test("independent");
        issue(OP_ADDI, 1, 0, 0, 5);
        issue(OP_ADDI, 2, 0, 0, -3);
        issue(OP_ADDI, 3, 0, 0, 'h1234);
        drain();
        issue(OP_ADD, 4, 1, 2, 0);
        issue(OP_SUB, 5, 1, 3, 0);
        issue(OP_AND, 6, 3, 2, 0);
        issue(OP_OR, 7, 1, 3, 0);
        issue(OP_XOR, 8, 2, 3, 0);
        issue(OP_SLL, 9, 3, 1, 0);
        end_test();

        begin_test("chain");
        issue(OP_ADDI, 10, 1, 0, 7);
        issue(OP_ADD, 10, 10, 1, 0);
        issue(OP_SUB, 11, 10, 2, 0);
        issue(OP_XOR, 12, 11, 10, 0);
        issue(OP_SLL, 12, 12, 1, 0);
        issue(OP_OR, 13, 12, 11, 0);
        end_test();

        begin_test("multiply");
        issue(OP_MUL, 13, 3, 1, 0);
        issue(OP_ADD, 14, 1, 2, 0);  // May finish before the product.
        issue(OP_ADD, 15, 13, 1, 0);
        end_test();

        begin_test("write_after_write");
        issue(OP_MUL, 5, 3, 3, 0);
        issue(OP_ADDI, 5, 0, 0, 99);
        drain();  // Reader takes r5 from the register file.
        issue(OP_ADD, 6, 5, 1, 0);
        end_test();

        begin_test("random");
        for (int n = 0; n < 400; n++) begin
            rnd = $random(seed);
            issue(op_e'(rnd[2:0]), int'(rnd[7:4]), int'(rnd[11:8]), int'(rnd[15:12]),
                  $random(seed));
        end
        end_test();

        $display("Summary: %0d tests, %0d instructions, %0d errors", tests, issued, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
verilog/ooo_pkg.sv
verilog/reg_status.sv
verilog/dispatch.sv
verilog/rs_alu.sv
verilog/alu_exec.sv
verilog/ooo_core.sv
bench/ooo_core_sva.sv
bench/ooo_core_tb.sv

// File: verilog/alu_exec.sv
`timescale 1ns/100ps
`default_nettype none

module alu_exec #(
    parameter int MUL_LAT = 3
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 exec_valid,
    input  wire ooo_pkg::rs_entry_t             exec_entry,
    input  wire [ooo_pkg::REG_ADDR_W-1:0]       exec_rd,
    output logic                                alu_busy,
    output ooo_pkg::result_bus_t                result,
    output logic [ooo_pkg::REG_ADDR_W-1:0]      result_rd
);

    import ooo_pkg::*;

    localparam int CNT_W   = $clog2(MUL_LAT);
    localparam int SHAMT_W = $clog2(WORD_W);

    logic [CNT_W-1:0]      cnt;
    rs_entry_t             mul_q;
    logic [REG_ADDR_W-1:0] mul_rd;
    logic [WORD_W-1:0]     mul_prod;
    logic [WORD_W-1:0]     simple_out;

    assign alu_busy = (cnt != '0);
    assign mul_prod = mul_q.data_x * mul_q.data_y;  // Low word kept.

    always_comb begin
        case (exec_entry.op)
            OP_ADD, OP_ADDI: simple_out = exec_entry.data_x + exec_entry.data_y;
            OP_SUB:          simple_out = exec_entry.data_x - exec_entry.data_y;
            OP_AND:          simple_out = exec_entry.data_x & exec_entry.data_y;
            OP_OR:           simple_out = exec_entry.data_x | exec_entry.data_y;
            OP_XOR:          simple_out = exec_entry.data_x ^ exec_entry.data_y;
            OP_SLL:          simple_out = exec_entry.data_x << exec_entry.data_y[SHAMT_W-1:0];
            default:         simple_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= '0;
            result    <= '0;
            result_rd <= '0;
        end else begin
            result.valid <= 1'b0;
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    result    <= '{valid: 1'b1, tag: mul_q.tag_w, data: mul_prod};
                    result_rd <= mul_rd;
                end
            end else if (exec_valid) begin
                if (exec_entry.op == OP_MUL) begin
                    cnt <= CNT_W'(MUL_LAT - 1);
                end else begin
                    result    <= '{valid: 1'b1, tag: exec_entry.tag_w, data: simple_out};
                    result_rd <= exec_rd;
                end
            end
        end
    end

    // Multiply operands held while the countdown runs.
    always_ff @(posedge clk) begin
        if (exec_valid && !alu_busy && exec_entry.op == OP_MUL) begin
            mul_q  <= exec_entry;
            mul_rd <= exec_rd;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch (
    input  wire                                 issue_valid,
    input  wire ooo_pkg::instr_u                issue_instr,
    input  wire [ooo_pkg::TAG_W-1:0]            src_x_tag,
    input  wire [ooo_pkg::WORD_W-1:0]           src_x_data,
    input  wire [ooo_pkg::TAG_W-1:0]            src_y_tag,
    input  wire [ooo_pkg::WORD_W-1:0]           src_y_data,
    input  wire [ooo_pkg::TAG_W-1:0]            alloc_tag,
    input  wire [ooo_pkg::ALU_CNT-1:0]          slot_busy,
    output logic                                issue_ready,
    output logic [ooo_pkg::REG_ADDR_W-1:0]      src_x_addr,
    output logic [ooo_pkg::REG_ADDR_W-1:0]      src_y_addr,
    output logic                                alloc_valid,
    output logic [ooo_pkg::REG_ADDR_W-1:0]      alloc_rd,
    output logic [ooo_pkg::ALU_CNT-1:0]         slot_load,
    output ooo_pkg::rs_entry_t                  slot_entry,
    output logic [ooo_pkg::REG_ADDR_W-1:0]      slot_rd
);

    import ooo_pkg::*;

    op_e               op;
    logic              is_imm;
    logic [WORD_W-1:0] imm_ext;
    logic [ALU_CNT-1:0] free_sel;
    logic              accept;

    assign op      = op_e'(issue_instr.r_fmt.opcode[2:0]);
    assign is_imm  = (op == OP_ADDI);
    assign imm_ext = {{(WORD_W-IMM_W){issue_instr.i_fmt.imm[IMM_W-1]}},
                      issue_instr.i_fmt.imm};

    // Field positions of rd and rs agree in both formats.
    assign src_x_addr = issue_instr.r_fmt.rs;
    assign src_y_addr = issue_instr.r_fmt.rt;

    always_comb begin
        free_sel = '0;
        for (int i = ALU_CNT - 1; i >= 0; i--) begin
            if (!slot_busy[i]) begin
                free_sel    = '0;
                free_sel[i] = 1'b1;  // Lowest free slot wins.
            end
        end
    end

    assign issue_ready = ~&slot_busy;
    assign accept      = issue_valid && issue_ready;

    assign alloc_valid = accept;
    assign alloc_rd    = issue_instr.r_fmt.rd;
    assign slot_load   = accept ? free_sel : '0;
    assign slot_rd     = issue_instr.r_fmt.rd;

    always_comb begin
        slot_entry.op     = op;
        slot_entry.tag_x  = src_x_tag;
        slot_entry.data_x = src_x_data;
        slot_entry.tag_w  = alloc_tag;
        if (is_imm) begin
            slot_entry.tag_y  = '0;
            slot_entry.data_y = imm_ext;
        end else begin
            slot_entry.tag_y  = src_y_tag;
            slot_entry.data_y = src_y_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ooo_core.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_core #(
    parameter int MUL_LAT = 3
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 issue_valid,
    input  wire ooo_pkg::instr_u                issue_instr,
    output logic                                issue_ready,
    output ooo_pkg::result_bus_t                result0,
    output ooo_pkg::result_bus_t                result1,
    output logic [ooo_pkg::REG_ADDR_W-1:0]      result_rd0,
    output logic [ooo_pkg::REG_ADDR_W-1:0]      result_rd1
);

    import ooo_pkg::*;

    logic [REG_ADDR_W-1:0] src_x_addr;
    logic [REG_ADDR_W-1:0] src_y_addr;
    logic [TAG_W-1:0]      src_x_tag;
    logic [TAG_W-1:0]      src_y_tag;
    logic [WORD_W-1:0]     src_x_data;
    logic [WORD_W-1:0]     src_y_data;
    logic                  alloc_valid;
    logic [REG_ADDR_W-1:0] alloc_rd;
    logic [TAG_W-1:0]      alloc_tag;
    logic [ALU_CNT-1:0]    slot_load;
    rs_entry_t             slot_entry;
    logic [REG_ADDR_W-1:0] slot_rd;
    logic [ALU_CNT-1:0]    slot_busy;
    logic [ALU_CNT-1:0]    exec_valid;
    rs_entry_t             exec_entry0;
    rs_entry_t             exec_entry1;
    logic [REG_ADDR_W-1:0] exec_rd0;
    logic [REG_ADDR_W-1:0] exec_rd1;
    logic [ALU_CNT-1:0]    alu_busy;

    dispatch dispatch_inst (
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .src_x_tag   (src_x_tag),
        .src_x_data  (src_x_data),
        .src_y_tag   (src_y_tag),
        .src_y_data  (src_y_data),
        .alloc_tag   (alloc_tag),
        .slot_busy   (slot_busy),
        .issue_ready (issue_ready),
        .src_x_addr  (src_x_addr),
        .src_y_addr  (src_y_addr),
        .alloc_valid (alloc_valid),
        .alloc_rd    (alloc_rd),
        .slot_load   (slot_load),
        .slot_entry  (slot_entry),
        .slot_rd     (slot_rd)
    );

    reg_status reg_status_inst (
        .clk         (clk),
        .rst         (rst),
        .src_x_addr  (src_x_addr),
        .src_y_addr  (src_y_addr),
        .alloc_valid (alloc_valid),
        .alloc_rd    (alloc_rd),
        .result0     (result0),
        .result1     (result1),
        .result_rd0  (result_rd0),
        .result_rd1  (result_rd1),
        .src_x_tag   (src_x_tag),
        .src_x_data  (src_x_data),
        .src_y_tag   (src_y_tag),
        .src_y_data  (src_y_data),
        .alloc_tag   (alloc_tag)
    );

    rs_alu rs_alu_inst (
        .clk         (clk),
        .rst         (rst),
        .slot_load   (slot_load),
        .slot_entry  (slot_entry),
        .slot_rd     (slot_rd),
        .result0     (result0),
        .result1     (result1),
        .alu_busy    (alu_busy),
        .slot_busy   (slot_busy),
        .exec_valid  (exec_valid),
        .exec_entry0 (exec_entry0),
        .exec_entry1 (exec_entry1),
        .exec_rd0    (exec_rd0),
        .exec_rd1    (exec_rd1)
    );

    // ALU i serves slot i and drives bus i.
    alu_exec #(.MUL_LAT(MUL_LAT)) alu0_inst (
        .clk        (clk),
        .rst        (rst),
        .exec_valid (exec_valid[0]),
        .exec_entry (exec_entry0),
        .exec_rd    (exec_rd0),
        .alu_busy   (alu_busy[0]),
        .result     (result0),
        .result_rd  (result_rd0)
    );

    alu_exec #(.MUL_LAT(MUL_LAT)) alu1_inst (
        .clk        (clk),
        .rst        (rst),
        .exec_valid (exec_valid[1]),
        .exec_entry (exec_entry1),
        .exec_rd    (exec_rd1),
        .alu_busy   (alu_busy[1]),
        .result     (result1),
        .result_rd  (result_rd1)
    );

endmodule

`default_nettype wire

// File: verilog/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_CNT    = 16;
    localparam int REG_ADDR_W = 4;
    localparam int TAG_W      = 4;   // Tag 0 means unlocked.
    localparam int ALU_CNT    = 2;
    localparam int OPC_W      = 6;
    localparam int IMM_W      = 16;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_ADDI,
        OP_MUL
    } op_e;

    typedef struct packed {
        logic [OPC_W-1:0]                        opcode;  // Low 3 bits used.
        logic [REG_ADDR_W-1:0]                   rd;
        logic [REG_ADDR_W-1:0]                   rs;
        logic [REG_ADDR_W-1:0]                   rt;
        logic [WORD_W-OPC_W-3*REG_ADDR_W-1:0]    unused;
    } r_fmt_t;

    typedef struct packed {
        logic [OPC_W-1:0]                              opcode;
        logic [REG_ADDR_W-1:0]                         rd;
        logic [REG_ADDR_W-1:0]                         rs;
        logic [WORD_W-OPC_W-2*REG_ADDR_W-IMM_W-1:0]    pad;
        logic [IMM_W-1:0]                              imm;  // Sign-extended.
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        op_e               op;
        logic [TAG_W-1:0]  tag_x;
        logic [TAG_W-1:0]  tag_y;
        logic [WORD_W-1:0] data_x;
        logic [WORD_W-1:0] data_y;
        logic [TAG_W-1:0]  tag_w;
    } rs_entry_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [WORD_W-1:0] data;
    } result_bus_t;

endpackage

`default_nettype wire

// File: verilog/reg_status.sv
`timescale 1ns/100ps
`default_nettype none

module reg_status (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire [ooo_pkg::REG_ADDR_W-1:0]       src_x_addr,
    input  wire [ooo_pkg::REG_ADDR_W-1:0]       src_y_addr,
    input  wire                                 alloc_valid,
    input  wire [ooo_pkg::REG_ADDR_W-1:0]       alloc_rd,
    input  wire ooo_pkg::result_bus_t           result0,
    input  wire ooo_pkg::result_bus_t           result1,
    input  wire [ooo_pkg::REG_ADDR_W-1:0]       result_rd0,
    input  wire [ooo_pkg::REG_ADDR_W-1:0]       result_rd1,
    output logic [ooo_pkg::TAG_W-1:0]           src_x_tag,
    output logic [ooo_pkg::WORD_W-1:0]          src_x_data,
    output logic [ooo_pkg::TAG_W-1:0]           src_y_tag,
    output logic [ooo_pkg::WORD_W-1:0]          src_y_data,
    output logic [ooo_pkg::TAG_W-1:0]           alloc_tag
);

    import ooo_pkg::*;

    logic [WORD_W-1:0]     regs [REG_CNT];
    logic [TAG_W-1:0]      tags [REG_CNT];
    logic [TAG_W-1:0]      last_tag;
    result_bus_t           bus [ALU_CNT];
    logic [REG_ADDR_W-1:0] bus_rd [ALU_CNT];

    assign bus[0]    = result0;
    assign bus[1]    = result1;
    assign bus_rd[0] = result_rd0;
    assign bus_rd[1] = result_rd1;

    // Operand lookup for dispatch.
    assign src_x_tag  = tags[src_x_addr];
    assign src_x_data = regs[src_x_addr];
    assign src_y_tag  = tags[src_y_addr];
    assign src_y_data = regs[src_y_addr];

    // Wraps from the top value back to 1.
    assign alloc_tag = (&last_tag) ? TAG_W'(1) : last_tag + TAG_W'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < REG_CNT; r++) begin
                regs[r] <= '0;
                tags[r] <= '0;
            end
            last_tag <= '0;
        end else begin
            // Only the current writer of a register may update it.
            for (int b = 0; b < ALU_CNT; b++) begin
                if (bus[b].valid && tags[bus_rd[b]] == bus[b].tag) begin
                    regs[bus_rd[b]] <= bus[b].data;
                    tags[bus_rd[b]] <= '0;
                end
            end
            // Later assignment wins over the writeback above.
            if (alloc_valid) begin
                tags[alloc_rd] <= alloc_tag;
                last_tag       <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rs_alu.sv
`timescale 1ns/100ps
`default_nettype none

module rs_alu (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire [ooo_pkg::ALU_CNT-1:0]          slot_load,
    input  wire ooo_pkg::rs_entry_t             slot_entry,
    input  wire [ooo_pkg::REG_ADDR_W-1:0]       slot_rd,
    input  wire ooo_pkg::result_bus_t           result0,
    input  wire ooo_pkg::result_bus_t           result1,
    input  wire [ooo_pkg::ALU_CNT-1:0]          alu_busy,
    output logic [ooo_pkg::ALU_CNT-1:0]         slot_busy,
    output logic [ooo_pkg::ALU_CNT-1:0]         exec_valid,
    output ooo_pkg::rs_entry_t                  exec_entry0,
    output ooo_pkg::rs_entry_t                  exec_entry1,
    output logic [ooo_pkg::REG_ADDR_W-1:0]      exec_rd0,
    output logic [ooo_pkg::REG_ADDR_W-1:0]      exec_rd1
);

    import ooo_pkg::*;

    rs_entry_t             slot_q [ALU_CNT];
    logic [REG_ADDR_W-1:0] rd_q [ALU_CNT];

    // Swap in bus data for a matching tag.
    function automatic logic [TAG_W+WORD_W-1:0] capture(
        input logic [TAG_W-1:0]  tag,
        input logic [WORD_W-1:0] data,
        input result_bus_t       b0,
        input result_bus_t       b1
    );
        logic [TAG_W+WORD_W-1:0] res;
        res = {tag, data};
        if (b0.valid && tag == b0.tag) begin
            res = {TAG_W'(0), b0.data};
        end else if (b1.valid && tag == b1.tag) begin
            res = {TAG_W'(0), b1.data};
        end
        return res;
    endfunction

    function automatic rs_entry_t snoop(
        input rs_entry_t   e,
        input result_bus_t b0,
        input result_bus_t b1
    );
        rs_entry_t n;
        n = e;
        {n.tag_x, n.data_x} = capture(e.tag_x, e.data_x, b0, b1);
        {n.tag_y, n.data_y} = capture(e.tag_y, e.data_y, b0, b1);
        return n;
    endfunction

    for (genvar i = 0; i < ALU_CNT; i++) begin : g_slot
        logic                  occupied;
        rs_entry_t             entry_q;
        logic [REG_ADDR_W-1:0] dest_q;

        assign exec_valid[i] = occupied && entry_q.tag_x == '0 && entry_q.tag_y == '0
                               && !alu_busy[i];
        assign slot_busy[i]  = occupied;
        assign slot_q[i]     = entry_q;
        assign rd_q[i]       = dest_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                occupied <= 1'b0;
                entry_q  <= '0;
                dest_q   <= '0;
            end else if (slot_load[i]) begin
                occupied <= 1'b1;
                entry_q  <= snoop(slot_entry, result0, result1);  // Capture on entry.
                dest_q   <= slot_rd;
            end else if (exec_valid[i]) begin
                occupied <= 1'b0;  // Leaves on the firing edge.
            end else if (occupied) begin
                entry_q  <= snoop(entry_q, result0, result1);
            end
        end
    end

    assign exec_entry0 = slot_q[0];
    assign exec_entry1 = slot_q[1];
    assign exec_rd0    = rd_q[0];
    assign exec_rd1    = rd_q[1];

endmodule

`default_nettype wire
